// File: rtl/revo_pkg.sv
package revo_pkg;

	// Timing, in clock127 cycles
	localparam int RESET_HOLD_CYCLES  = 64;
	localparam int TRG_MAX_DURATION   = 8;
	localparam int QUIET_CYCLES       = 8;
	localparam int SYNC_STAGES        = 2;
	localparam int LED_STRETCH_CYCLES = 32;

	// Calibration word geometry
	localparam int CAL_WORD_BITS = 8;

	typedef logic [CAL_WORD_BITS-1:0] cal_word_t;

	// Position inside the calibration word
	typedef logic [$clog2(CAL_WORD_BITS)-1:0] cal_index_t;

	// Accepted markers, wraps at 16
	typedef logic [3:0] trig_count_t;

	// Pulse length and quiet length
	typedef logic [3:0] run_len_t;

	typedef logic [6:0] hold_count_t;

	typedef logic [5:0] stretch_count_t;

	// Qualifier FSM
	typedef enum logic [1:0] {
		Q_WAIT_QUIET,
		Q_IDLE,
		Q_HIGH,
		Q_REJECT
	} qual_state_t;

endpackage

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ns

module reset_sequencer (
	input  logic clock127,
	input  logic arst_n,
	output logic ready
);

	revo_pkg::hold_count_t hold_count;

	// Datapath stays off until the hold time has elapsed
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			hold_count <= '0;
			ready      <= 1'b0;
		end else if (!ready) begin
			if (hold_count == revo_pkg::hold_count_t'(revo_pkg::RESET_HOLD_CYCLES - 1)) begin
				ready <= 1'b1;
			end else begin
				hold_count <= hold_count + 1'b1;
			end
		end
	end

endmodule

// File: rtl/revo_pulse_qualifier.sv
`timescale 1ns/1ns

module revo_pulse_qualifier (
	input  logic clock127,
	input  logic arst_n,
	input  logic ready,
	input  logic revo_in,
	output logic trig
);

	logic [revo_pkg::SYNC_STAGES-1:0] sync_q;
	logic                             revo_s;
	revo_pkg::qual_state_t            state;
	revo_pkg::run_len_t               run_len;
	logic                             accept;

	// Strobe comes from a remote source
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[revo_pkg::SYNC_STAGES-2:0], revo_in};
		end
	end

	assign revo_s = sync_q[revo_pkg::SYNC_STAGES-1];

	// run_len counts low samples while waiting for quiet, high samples during a pulse
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= revo_pkg::Q_WAIT_QUIET;
			run_len <= '0;
			accept  <= 1'b0;
		end else if (!ready) begin
			state   <= revo_pkg::Q_WAIT_QUIET;
			run_len <= '0;
			accept  <= 1'b0;
		end else begin
			accept <= 1'b0;
			case (state)
				revo_pkg::Q_WAIT_QUIET: begin
					// Any high sample restarts the quiet period
					if (revo_s) begin
						run_len <= '0;
					end else if (run_len ==
							revo_pkg::run_len_t'(revo_pkg::QUIET_CYCLES - 1)) begin
						state   <= revo_pkg::Q_IDLE;
						run_len <= '0;
					end else begin
						run_len <= run_len + 1'b1;
					end
				end
				revo_pkg::Q_IDLE: begin
					if (revo_s) begin
						state   <= revo_pkg::Q_HIGH;
						run_len <= revo_pkg::run_len_t'(1);
					end
				end
				revo_pkg::Q_HIGH: begin
					if (!revo_s) begin
						// Short pulse has ended, this low sample starts the next quiet
						accept  <= 1'b1;
						state   <= revo_pkg::Q_WAIT_QUIET;
						run_len <= revo_pkg::run_len_t'(1);
					end else if (run_len ==
							revo_pkg::run_len_t'(revo_pkg::TRG_MAX_DURATION)) begin
						state   <= revo_pkg::Q_REJECT;
						run_len <= '0;
					end else begin
						run_len <= run_len + 1'b1;
					end
				end
				revo_pkg::Q_REJECT: begin
					if (!revo_s) begin
						state   <= revo_pkg::Q_WAIT_QUIET;
						run_len <= revo_pkg::run_len_t'(1);
					end
				end
				default: begin
					state   <= revo_pkg::Q_WAIT_QUIET;
					run_len <= '0;
				end
			endcase
		end
	end

	// Decision register
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			trig <= 1'b0;
		end else begin
			trig <= accept & ready;
		end
	end

endmodule

// File: rtl/revo_clock_encoder.sv
`timescale 1ns/1ns

module revo_clock_encoder (
	input  logic clock127,
	input  logic arst_n,
	input  logic ready,
	input  logic trig,
	output logic clk_fwd_rise_bit,
	output logic clk_fwd_fall_bit
);

	// DDR pair of the forwarded clock
	// Rise bit 0 and fall bit 1 give one full period per clock127 cycle
	// A marker removes the rising edge that the 0 to 1 step would produce
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			clk_fwd_rise_bit <= 1'b0;
			clk_fwd_fall_bit <= 1'b0;
		end else if (!ready) begin
			clk_fwd_rise_bit <= 1'b0;
			clk_fwd_fall_bit <= 1'b0;
		end else begin
			clk_fwd_rise_bit <= 1'b0;
			clk_fwd_fall_bit <= ~trig;
		end
	end

endmodule

// File: rtl/calibration_serializer.sv
`timescale 1ns/1ns

module calibration_serializer (
	input  logic                clock127,
	input  logic                arst_n,
	input  logic                ready,
	input  revo_pkg::cal_word_t cal_word,
	output logic                cal_bit,
	output logic                cal_word_start
);

	revo_pkg::cal_word_t  shift_q;
	revo_pkg::cal_index_t bit_idx;

	// bit_idx is the number of bits still to follow the one on cal_bit
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			shift_q        <= '0;
			bit_idx        <= '0;
			cal_word_start <= 1'b0;
		end else if (!ready) begin
			shift_q        <= '0;
			bit_idx        <= '0;
			cal_word_start <= 1'b0;
		end else if (bit_idx == '0) begin
			// Word boundary, pick up the current word
			shift_q        <= cal_word;
			bit_idx        <= revo_pkg::cal_index_t'(revo_pkg::CAL_WORD_BITS - 1);
			cal_word_start <= 1'b1;
		end else begin
			shift_q        <= {shift_q[revo_pkg::CAL_WORD_BITS-2:0], 1'b0};
			bit_idx        <= bit_idx - 1'b1;
			cal_word_start <= 1'b0;
		end
	end

	// MSB first
	assign cal_bit = shift_q[revo_pkg::CAL_WORD_BITS-1];

endmodule

// File: rtl/status_indicator.sv
`timescale 1ns/1ns

module status_indicator (
	input  logic                  clock127,
	input  logic                  arst_n,
	input  logic                  ready,
	input  logic                  trig,
	output logic                  led_ready,
	output logic                  led_trig,
	output revo_pkg::trig_count_t trig_count
);

	revo_pkg::stretch_count_t stretch;

	// A new trigger restarts the stretch
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			stretch <= '0;
		end else if (!ready) begin
			stretch <= '0;
		end else if (trig) begin
			stretch <= revo_pkg::stretch_count_t'(revo_pkg::LED_STRETCH_CYCLES);
		end else if (stretch != '0) begin
			stretch <= stretch - 1'b1;
		end
	end

	assign led_trig = (stretch != '0);

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			led_ready  <= 1'b0;
			trig_count <= '0;
		end else begin
			led_ready <= ready;
			if (!ready) begin
				trig_count <= '0;
			end else if (trig) begin
				trig_count <= trig_count + 1'b1; // wraps
			end
		end
	end

endmodule

// File: rtl/revo_encoder_top.sv
`timescale 1ns/1ns

module revo_encoder_top (
	input  logic                  clock127,
	input  logic                  arst_n,
	input  logic                  revo_in,
	input  revo_pkg::cal_word_t   cal_word,
	output logic                  clk_fwd_rise_bit,
	output logic                  clk_fwd_fall_bit,
	output logic                  trig_out,
	output logic                  cal_bit,
	output logic                  cal_word_start,
	output logic                  led_ready,
	output logic                  led_trig,
	output revo_pkg::trig_count_t trig_count
);

	logic ready;

	reset_sequencer u_reset_sequencer (
		.clock127 (clock127),
		.arst_n   (arst_n),
		.ready    (ready)
	);

	// trig_out doubles as the internal marker strobe
	revo_pulse_qualifier u_revo_pulse_qualifier (
		.clock127 (clock127),
		.arst_n   (arst_n),
		.ready    (ready),
		.revo_in  (revo_in),
		.trig     (trig_out)
	);

	revo_clock_encoder u_revo_clock_encoder (
		.clock127         (clock127),
		.arst_n           (arst_n),
		.ready            (ready),
		.trig             (trig_out),
		.clk_fwd_rise_bit (clk_fwd_rise_bit),
		.clk_fwd_fall_bit (clk_fwd_fall_bit)
	);

	calibration_serializer u_calibration_serializer (
		.clock127       (clock127),
		.arst_n         (arst_n),
		.ready          (ready),
		.cal_word       (cal_word),
		.cal_bit        (cal_bit),
		.cal_word_start (cal_word_start)
	);

	status_indicator u_status_indicator (
		.clock127   (clock127),
		.arst_n     (arst_n),
		.ready      (ready),
		.trig       (trig_out),
		.led_ready  (led_ready),
		.led_trig   (led_trig),
		.trig_count (trig_count)
	);

endmodule

// File: dv/revo_encoder_sva.sv
`timescale 1ns/1ns

module revo_encoder_sva (
	input logic clock127,
	input logic arst_n,
	input logic trig_out,
	input logic clk_fwd_rise_bit,
	input logic clk_fwd_fall_bit,
	input logic cal_word_start
);

	logic       started;
	logic [3:0] since_start;

	// Cycles since the last word start
	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			started     <= 1'b0;
			since_start <= '0;
		end else if (cal_word_start) begin
			started     <= 1'b1;
			since_start <= 4'd1;
		end else if (started) begin
			since_start <= since_start + 4'd1;
		end
	end

	trig_single: assert property (@(posedge clock127) disable iff (!arst_n)
		trig_out |=> !trig_out)
		else $error("trig_out high on two consecutive cycles");

	fwd_pair_legal: assert property (@(posedge clock127) disable iff (!arst_n)
		!(clk_fwd_rise_bit && !clk_fwd_fall_bit))
		else $error("forwarded pair reads 1 then 0");

	start_not_early: assert property (@(posedge clock127) disable iff (!arst_n)
		(started && cal_word_start) |-> since_start == 4'(revo_pkg::CAL_WORD_BITS))
		else $error("cal_word_start came before the word ended");

	start_not_late: assert property (@(posedge clock127) disable iff (!arst_n)
		(started && since_start == 4'(revo_pkg::CAL_WORD_BITS)) |-> cal_word_start)
		else $error("cal_word_start missing at the word boundary");

endmodule

// File: dv/revo_encoder_tb.sv
`timescale 1ns/1ns

module revo_encoder_tb;

	logic                  clock127;
	logic                  arst_n;
	logic                  revo_in;
	revo_pkg::cal_word_t   cal_word;
	logic                  clk_fwd_rise_bit;
	logic                  clk_fwd_fall_bit;
	logic                  trig_out;
	logic                  cal_bit;
	logic                  cal_word_start;
	logic                  led_ready;
	logic                  led_trig;
	revo_pkg::trig_count_t trig_count;

	logic                arst_drive;
	revo_pkg::cal_word_t cal_drive;
	integer              seed;
	int                  errors;
	int                  checks;
	int                  tests_run;
	int                  trig_seen;
	int                  errors_at_start;
	string               test_name;

	revo_encoder_top u_dut (
		.clock127         (clock127),
		.arst_n           (arst_n),
		.revo_in          (revo_in),
		.cal_word         (cal_word),
		.clk_fwd_rise_bit (clk_fwd_rise_bit),
		.clk_fwd_fall_bit (clk_fwd_fall_bit),
		.trig_out         (trig_out),
		.cal_bit          (cal_bit),
		.cal_word_start   (cal_word_start),
		.led_ready        (led_ready),
		.led_trig         (led_trig),
		.trig_count       (trig_count)
	);

	bind revo_encoder_top revo_encoder_sva u_sva (
		.clock127         (clock127),
		.arst_n           (arst_n),
		.trig_out         (trig_out),
		.clk_fwd_rise_bit (clk_fwd_rise_bit),
		.clk_fwd_fall_bit (clk_fwd_fall_bit),
		.cal_word_start   (cal_word_start)
	);

	initial begin
		clock127 = 1'b0;
		forever #2 clock127 = ~clock127;
	end

	// Inputs change on the rising edge and outputs are read on the falling edge
	task automatic drive_cycle(input logic revo);
		@(posedge clock127);
		arst_n   <= arst_drive;
		revo_in  <= revo;
		cal_word <= cal_drive;
		@(negedge clock127);
		if (trig_out) begin
			trig_seen++;
		end
	endtask

	task automatic hold_quiet(input int cycles);
		repeat (cycles) drive_cycle(1'b0);
	endtask

	task automatic drive_pulse(input int width);
		repeat (width) drive_cycle(1'b1);
		drive_cycle(1'b0);
	endtask

	// Edges from the first low sample of revo_in to trig_out, or -1 without a trig_out
	task automatic watch_trig(output int edges);
		int n;
		edges = -1;
		for (n = 1; n <= revo_pkg::QUIET_CYCLES + revo_pkg::TRG_MAX_DURATION; n++) begin
			drive_cycle(1'b0);
			if (trig_out) begin
				edges = n - 1;
				break;
			end
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_word(input string what, input revo_pkg::cal_word_t expected,
			input revo_pkg::cal_word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input revo_pkg::trig_count_t expected,
			input revo_pkg::trig_count_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic check_latency(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s done, %0d error(s)", test_name, errors - errors_at_start);
	endtask

	task automatic check_idle_outputs();
		check_bit("trig_out idle", 1'b0, trig_out);
		check_bit("cal_word_start idle", 1'b0, cal_word_start);
		check_bit("cal_bit idle", 1'b0, cal_bit);
		check_bit("led_trig idle", 1'b0, led_trig);
		check_bit("led_ready idle", 1'b0, led_ready);
		check_bit("rise bit idle", 1'b0, clk_fwd_rise_bit);
		check_bit("fall bit idle", 1'b0, clk_fwd_fall_bit);
		check_count("trig_count idle", '0, trig_count);
	endtask

	task automatic test_reset_ready();
		int n;
		begin_test("reset_ready");
		arst_drive = 1'b0;
		repeat (4) begin
			drive_cycle(1'b0);
			check_idle_outputs();
		end
		arst_drive = 1'b1;
		drive_cycle(1'b0);
		check_idle_outputs();
		for (n = 0; n < revo_pkg::RESET_HOLD_CYCLES + 8 && !led_ready; n++) begin
			drive_cycle(1'b0);
		end
		if (!led_ready) begin
			report_problem("led_ready did not rise within the reset hold time");
		end else begin
			// The last hold edge sets ready and led_ready follows one edge later
			check_latency("led_ready delay", revo_pkg::RESET_HOLD_CYCLES + 1, n);
			repeat (8) begin
				drive_cycle(1'b0);
				check_bit("rise bit running", 1'b0, clk_fwd_rise_bit);
				check_bit("fall bit running", 1'b1, clk_fwd_fall_bit);
			end
		end
		end_test();
	endtask

	task automatic test_accepted_marker();
		int widths[2];
		int i;
		int edges;
		int seen_before;
		begin_test("accepted_marker");
		widths[0] = 1;
		widths[1] = revo_pkg::TRG_MAX_DURATION;
		for (i = 0; i < 2; i++) begin
			hold_quiet(revo_pkg::QUIET_CYCLES + 4);
			seen_before = trig_seen;
			drive_pulse(widths[i]);
			watch_trig(edges);
			if (edges < 0) begin
				report_problem($sformatf("no trig_out after a pulse of width %0d", widths[i]));
			end else begin
				// Two synchroniser stages plus the decision register
				check_latency("trig latency", revo_pkg::SYNC_STAGES + 1, edges);
				drive_cycle(1'b0);
				check_bit("trig_out one cycle", 1'b0, trig_out);
				check_bit("rise bit at marker", 1'b0, clk_fwd_rise_bit);
				check_bit("fall bit at marker", 1'b0, clk_fwd_fall_bit);
				drive_cycle(1'b0);
				check_bit("rise bit after marker", 1'b0, clk_fwd_rise_bit);
				check_bit("fall bit after marker", 1'b1, clk_fwd_fall_bit);
				check_count("trig pulses per marker", 4'd1,
					revo_pkg::trig_count_t'(trig_seen - seen_before));
			end
		end
		end_test();
	endtask

	task automatic test_rejected_pulses();
		int edges;
		int seen_before;
		revo_pkg::trig_count_t count_before;
		begin_test("rejected_pulses");
		hold_quiet(revo_pkg::QUIET_CYCLES + 4);
		count_before = trig_count;
		seen_before  = trig_seen;
		drive_pulse(revo_pkg::TRG_MAX_DURATION + 1);
		watch_trig(edges);
		check_count("trig pulses after long pulse", '0,
			revo_pkg::trig_count_t'(trig_seen - seen_before));
		check_count("trig_count after long pulse", count_before, trig_count);
		// Short pulse lands inside the quiet period after a rejected one
		drive_pulse(revo_pkg::TRG_MAX_DURATION + 1);
		hold_quiet(revo_pkg::QUIET_CYCLES / 2);
		drive_pulse(1);
		watch_trig(edges);
		check_count("trig pulses after early pulse", '0,
			revo_pkg::trig_count_t'(trig_seen - seen_before));
		check_count("trig_count after early pulse", count_before, trig_count);
		end_test();
	endtask

	task automatic wait_word_start(output bit found);
		int n;
		found = 1'b0;
		for (n = 0; n < 2 * revo_pkg::CAL_WORD_BITS + 4; n++) begin
			drive_cycle(1'b0);
			if (cal_word_start) begin
				found = 1'b1;
				break;
			end
		end
		if (!found) begin
			report_problem("cal_word_start did not appear");
		end
	endtask

	// Called on the cycle that shows cal_word_start
	task automatic collect_word(output revo_pkg::cal_word_t word);
		int n;
		word = '0;
		for (n = 0; n < revo_pkg::CAL_WORD_BITS; n++) begin
			if (n > 0) begin
				drive_cycle(1'b0);
			end
			word = {word[revo_pkg::CAL_WORD_BITS-2:0], cal_bit};
		end
	endtask

	task automatic test_calibration_stream();
		revo_pkg::cal_word_t first_word;
		revo_pkg::cal_word_t second_word;
		revo_pkg::cal_word_t got;
		bit                  found;
		begin_test("calibration_stream");
		first_word  = revo_pkg::cal_word_t'($random(seed));
		second_word = ~first_word;
		cal_drive   = first_word;
		// Applies the word before the boundary that is waited for
		drive_cycle(1'b0);
		wait_word_start(found);
		if (found) begin
			collect_word(got);
			check_word("first word", first_word, got);
			wait_word_start(found);
		end
		if (found) begin
			// New word arrives in the middle of this one
			cal_drive = second_word;
			collect_word(got);
			check_word("word in flight", first_word, got);
			wait_word_start(found);
		end
		if (found) begin
			collect_word(got);
			check_word("word after change", second_word, got);
		end
		end_test();
	endtask

	task automatic test_status();
		int i;
		int edges;
		revo_pkg::trig_count_t count_before;
		begin_test("status");
		count_before = trig_count;
		for (i = 0; i < 3; i++) begin
			hold_quiet(revo_pkg::QUIET_CYCLES + 4);
			drive_pulse(i + 2);
			watch_trig(edges);
			if (edges < 0) begin
				report_problem($sformatf("no trig_out for marker %0d", i));
			end
		end
		drive_cycle(1'b0);
		check_count("trig_count", revo_pkg::trig_count_t'(count_before + 3), trig_count);
		check_bit("led_trig after trig", 1'b1, led_trig);
		for (i = 1; i < revo_pkg::LED_STRETCH_CYCLES; i++) begin
			drive_cycle(1'b0);
			check_bit("led_trig stretched", 1'b1, led_trig);
		end
		drive_cycle(1'b0);
		check_bit("led_trig released", 1'b0, led_trig);
		end_test();
	endtask

	initial begin
		arst_n     = 1'b0;
		arst_drive = 1'b0;
		revo_in    = 1'b0;
		cal_word   = '0;
		cal_drive  = '0;
		seed       = 32'hb384b251;
		errors     = 0;
		checks     = 0;
		tests_run  = 0;
		trig_seen  = 0;
		test_name  = "";
		test_reset_ready();
		test_accepted_marker();
		test_rejected_pulses();
		test_calibration_stream();
		test_status();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/revo_pkg.sv
rtl/reset_sequencer.sv
rtl/revo_pulse_qualifier.sv
rtl/revo_clock_encoder.sv
rtl/calibration_serializer.sv
rtl/status_indicator.sv
rtl/revo_encoder_top.sv
dv/revo_encoder_sva.sv
dv/revo_encoder_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module revo_encoder_tb \
	-f list.f -o revo_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/revo_sim > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1
